/* cpu_testdata.txt */
# T name | P up to eight instruction words (hex) | S up to four store pairs, addr data (hex)
# E ends the test, the program must reach HALT
T aluOps
P 6219 6439 0650 8600 1888 8801 2A50 8A02
P 3A50 8A03 4A50 8A04 5C88 8C05 5E50 8E06
P F000
S 00 0012 01 FFE0 02 0019 03 FFF9
S 04 FFE0 05 0001 06 0000
E
T addiZeroReg
P 623F 6260 6005 0048 8200 8001 641F 84BF
P F000
S 00 FFDF 01 0000 1E 001F
E
T memRoundTrip
P 620D 642C 660A 82C0 84C1 86F6 78C1 7AC0
P 7C00 8814 8A15 8C16 F000
S 0A 000D 0B FFEC 00 000A 14 FFEC
S 15 000D 16 000A
E
T controlFlow
P 6203 6403 9281 8200 8401 9201 8202 A00B
P 8003 F000 8003 627F 8248 9201 903C F000
S 01 0003 02 0003 0A 0002 09 0001
S 08 0000
E
T haltHold
P 6207 8205 F000 8206 A000
S 05 0007
E

/* src.f */
+incdir+.
cpu_pkg.sv
ram_block.sv
reg_file.sv
alu.sv
cpu_core.sv
cpu_system.sv
cpu_asserts.sv
cpu_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP      = cpuTb
FILELIST = src.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run the simulation, log to $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation reported failures"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

// programs and expected stores come from cpu_testdata.txt.
module cpuTb;

    logic                    clock;
    logic                    rstN;
    logic                    progWe;
    logic [`CPU_IMEM_AW-1:0] progAddr;
    logic [15:0]             progData;
    logic                    storeValid;
    logic [`CPU_DMEM_AW-1:0] storeAddr;
    logic [15:0]             storeData;
    logic                    halted;

    logic [15:0]             progWords [$];      // program of the current test.
    logic [`CPU_DMEM_AW-1:0] expAddr [$];
    logic [15:0]             expData [$];
    logic [`CPU_DMEM_AW-1:0] obsAddr [$];        // stores seen on the pins.
    logic [15:0]             obsData [$];
    logic [8*16-1:0]         testName;
    logic [31:0]             rng;
    int                      errorCount;
    int                      passCount;
    int                      failCount;
    bit                      timedOut;           // a program never reached HALT.

    cpuSystem dut (
        .clock      (clock),
        .rstN       (rstN),
        .progWe     (progWe),
        .progAddr   (progAddr),
        .progData   (progData),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData),
        .halted     (halted)
    );

    always #50 clock = ~clock;                   // 100 ns period.

    // a store is taken on the rising edge that retires it.
    always @(posedge clock) begin
        if (rstN && storeValid) begin
            obsAddr.push_back(storeAddr);
            obsData.push_back(storeData);
        end
    end

    // ********************
    // helpers.
    // ********************
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // opcode, rd, rs, then rt field or immediate.
    function automatic logic [15:0] encode(input logic [3:0] op, input logic [2:0] rd,
                                           input logic [2:0] rs, input logic [5:0] low);
        return {op, rd, rs, low};
    endfunction

    task automatic checkEqual(input logic [15:0] got, input logic [15:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("** Error @ %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            errorCount++;
        end
    endtask

    task automatic finishRun();
        $display("%0d tests passed, %0d tests failed, %0d errors",
                 passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    // reset stays low while the program goes in one word per cycle.
    task automatic loadProgram();
        int resetCycles;
        resetCycles = (progWords.size() > 16) ? progWords.size() : 16;
        for (int i = 0; i < resetCycles; i++) begin
            @(negedge clock);
            rstN     = 1'b0;
            progWe   = (i < progWords.size());
            progAddr = `CPU_IMEM_AW'(i);
            progData = (i < progWords.size()) ? progWords[i] : 16'h0000;
        end
        @(negedge clock);
        progWe = 1'b0;
        rstN   = 1'b1;                           // pc 0 runs on the next edge.
    endtask

    // ********************
    // one test.
    // ********************
    task automatic runTest();
        int limit;
        int cycles;
        int seen;
        int errBefore;
        bit dropped;
        errBefore = errorCount;
        limit     = 4 * progWords.size() + 40;
        obsAddr.delete();
        obsData.delete();
        loadProgram();
        cycles = 0;
        while (!halted && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        if (!halted) begin
            $display("test %0s: no halt within %0d cycles, stopping", testName, limit);
            failCount++;
            timedOut = 1'b1;
        end else begin
            // after halt the core must stay parked and quiet.
            seen    = obsAddr.size();
            dropped = 1'b0;
            repeat (20) begin
                @(negedge clock);
                if (!halted) dropped = 1'b1;
            end
            if (obsAddr.size() != seen) begin
                $display("test %0s: stores appeared after halt", testName);
                errorCount++;
            end
            if (dropped) begin
                $display("test %0s: halted fell before reset", testName);
                errorCount++;
            end
            if (obsAddr.size() != expAddr.size()) begin
                $display("test %0s: %0d stores seen but %0d expected",
                         testName, obsAddr.size(), expAddr.size());
                errorCount++;
            end
            for (int i = 0; i < obsAddr.size() && i < expAddr.size(); i++) begin
                checkEqual(16'(obsAddr[i]), 16'(expAddr[i]), $sformatf("store %0d address", i));
                checkEqual(obsData[i], expData[i], $sformatf("store %0d data", i));
            end
            if (errorCount == errBefore) begin
                passCount++;
                $display("test %0s passed, %0d stores", testName, obsAddr.size());
            end else begin
                failCount++;
                $display("test %0s failed", testName);
            end
        end
    endtask

    // T starts a test, P adds words, S adds address data pairs, E runs it.
    task automatic parseLine(input logic [8*100-1:0] lineBuf);
        logic [8*8-1:0] tag;
        logic [15:0]    fld [8];
        int             n;
        n = $sscanf(lineBuf, "%s %h %h %h %h %h %h %h %h", tag, fld[0], fld[1], fld[2],
                    fld[3], fld[4], fld[5], fld[6], fld[7]);
        if (n >= 1) begin
            if (tag == "T") begin
                progWords.delete();
                expAddr.delete();
                expData.delete();
                void'($sscanf(lineBuf, "%s %s", tag, testName));
            end else if (tag == "P") begin
                for (int i = 1; i < n; i++) progWords.push_back(fld[i-1]);
            end else if (tag == "S") begin
                for (int i = 1; i + 1 < n; i += 2) begin
                    expAddr.push_back(fld[i-1][`CPU_DMEM_AW-1:0]);
                    expData.push_back(fld[i]);
                end
            end else if (tag == "E") begin
                runTest();
            end
        end
    endtask

    // ADDI and ADD chain on r1 with the running sum stored after every step.
    task automatic buildRandomTest();
        logic [15:0] acc;
        logic [5:0]  immA;
        logic [5:0]  immB;
        progWords.delete();
        expAddr.delete();
        expData.delete();
        acc = 16'h0000;
        for (int k = 0; k < 8; k++) begin
            rng  = xorshift(rng);
            immA = rng[5:0];
            immB = rng[13:8];
            progWords.push_back(encode(cpuPkg::opAddi, 3'd2, 3'd0, immA));
            progWords.push_back(encode(cpuPkg::opAddi, 3'd1, 3'd1, immB));
            progWords.push_back(encode(cpuPkg::opAdd, 3'd1, 3'd1, {3'd2, 3'd0}));
            progWords.push_back(encode(cpuPkg::opSw, 3'd1, 3'd0, 6'(k + 24)));
            acc = acc + {{10{immA[5]}}, immA} + {{10{immB[5]}}, immB};
            expAddr.push_back(`CPU_DMEM_AW'(k + 24));
            expData.push_back(acc);
        end
        progWords.push_back(encode(cpuPkg::opHalt, 3'd0, 3'd0, 6'd0));
        testName = "randomAdd";
    endtask

    // ********************
    // main sequence.
    // ********************
    initial begin
        logic [8*100-1:0] lineBuf;
        int               fd;
        clock      = 1'b0;
        rstN       = 1'b0;
        progWe     = 1'b0;
        progAddr   = '0;
        progData   = 16'h0000;
        errorCount = 0;
        passCount  = 0;
        failCount  = 0;
        timedOut   = 1'b0;
        rng        = 32'h6c440edf;
        fd = $fopen("cpu_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open cpu_testdata.txt, no tests run");
            failCount++;
        end else begin
            while (!timedOut && !$feof(fd)) begin
                lineBuf = '0;
                if ($fgets(lineBuf, fd) > 0) parseLine(lineBuf);
            end
            $fclose(fd);
            if (!timedOut) begin
                buildRandomTest();
                runTest();
            end
        end
        finishRun();
    end

endmodule

`default_nettype wire

/* cpu_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

// pin level checks on the subsystem, bound into every cpuSystem.
module cpuAsserts (
    input wire logic clock,
    input wire logic rstN,
    input wire logic storeValid,
    input wire logic halted
);

    // ********************
    // halt behaviour.
    // ********************
    noStoreWhenHalted: assert property (@(posedge clock) halted |-> !storeValid)
        else $error("store request while the core is halted");

    // sticky until the next reset.
    haltSticky: assert property (@(posedge clock) (rstN && halted) |=> halted)
        else $error("halted fell while rstN was high");

    // ********************
    // reset.
    // ********************
    quietAfterReset: assert property (@(posedge clock) $fell(rstN) |=> (!storeValid && !halted))
        else $error("store or halt seen right after reset");

endmodule

bind cpuSystem cpuAsserts pinChecks (
    .clock      (clock),
    .rstN       (rstN),
    .storeValid (storeValid),
    .halted     (halted)
);

`default_nettype wire

/* cpu_system.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

// subsystem top, core plus instruction and data RAM.
module cpuSystem (
    input  wire logic                   clock,
    input  wire logic                   rstN,
    // program loader, meant for use while rstN is low.
    input  wire logic                   progWe,
    input  wire logic [`CPU_IMEM_AW-1:0] progAddr,
    input  wire cpuPkg::instrT          progData,
    // store observation.
    output logic                        storeValid,
    output logic [`CPU_DMEM_AW-1:0]     storeAddr,
    output cpuPkg::dataT                storeData,
    output logic                        halted
);

    // ********************
    // internal buses.
    // ********************
    logic [`CPU_IMEM_AW-1:0] imemAddr;
    cpuPkg::instrT           instr;
    logic [`CPU_DMEM_AW-1:0] dmemAddr;
    logic                    dmemWe;
    cpuPkg::dataT            dmemWrData;
    cpuPkg::dataT            dmemRdData;

    // every data write is visible at the pins.
    assign storeValid = dmemWe;
    assign storeAddr  = dmemAddr;
    assign storeData  = dmemWrData;

    // ********************
    // instruction memory.
    // ********************
    ramBlock #(
        .wordT     (cpuPkg::instrT),
        .depth     (`CPU_IMEM_DEPTH),
        .addrWidth (`CPU_IMEM_AW)
    ) imem (
        .clock  (clock),
        .we     (progWe),                        // loader side.
        .wrAddr (progAddr),
        .rdAddr (imemAddr),                      // fetch side.
        .wrData (progData),
        .rdData (instr)
    );

    // ********************
    // data memory.
    // ********************
    ramBlock #(
        .wordT     (cpuPkg::dataT),
        .depth     (`CPU_DMEM_DEPTH),
        .addrWidth (`CPU_DMEM_AW)
    ) dmem (
        .clock  (clock),
        .we     (dmemWe),
        .wrAddr (dmemAddr),                      // one address for both ports.
        .rdAddr (dmemAddr),
        .wrData (dmemWrData),
        .rdData (dmemRdData)
    );

    // ********************
    // processor.
    // ********************
    cpuCore core (
        .clock      (clock),
        .rstN       (rstN),
        .instr      (instr),
        .dmemRdData (dmemRdData),
        .imemAddr   (imemAddr),
        .dmemAddr   (dmemAddr),
        .dmemWe     (dmemWe),
        .dmemWrData (dmemWrData),
        .halted     (halted)
    );

endmodule

`default_nettype wire

/* cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

// single-cycle core, one instruction retires on every clock edge.
module cpuCore (
    input  wire logic                    clock,
    input  wire logic                    rstN,
    input  wire cpuPkg::instrT           instr,
    input  wire cpuPkg::dataT            dmemRdData,
    output logic [`CPU_IMEM_AW-1:0]      imemAddr,
    output logic [`CPU_DMEM_AW-1:0]      dmemAddr,
    output logic                         dmemWe,
    output cpuPkg::dataT                 dmemWrData,
    output logic                         halted
);

    // ********************
    // state and wires.
    // ********************
    logic [`CPU_IMEM_AW-1:0] pc;
    logic [`CPU_IMEM_AW-1:0] pcNext;
    logic [`CPU_IMEM_AW-1:0] pcPlus1;
    logic [`CPU_IMEM_AW-1:0] branchTarget;
    logic [`CPU_IMEM_AW-1:0] jumpTarget;
    logic                    haltedQ;            // sticky until reset.

    cpuPkg::aluOpT  aluOp;
    cpuPkg::regIdxT rdB;
    cpuPkg::dataT   immExt;
    cpuPkg::dataT   valA;
    cpuPkg::dataT   valB;
    cpuPkg::dataT   aluB;
    cpuPkg::dataT   aluY;
    cpuPkg::dataT   wbData;
    logic           aluZero;

    // decoded controls.
    logic useRt;                                 // second operand register is rt.
    logic useImm;                                // ALU b takes the immediate.
    logic regWe;
    logic memToReg;                              // writeback from data memory.
    logic isStore;
    logic isBranch;
    logic isJump;
    logic isHalt;

    // ********************
    // decode.
    // ********************
    always_comb begin
        aluOp    = cpuPkg::aluAdd;               // address and ADDI use add.
        useRt    = 1'b0;
        useImm   = 1'b0;
        regWe    = 1'b0;
        memToReg = 1'b0;
        isStore  = 1'b0;
        isBranch = 1'b0;
        isJump   = 1'b0;
        isHalt   = 1'b0;
        case (instr.opcode)
            cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd,
            cpuPkg::opOr, cpuPkg::opXor, cpuPkg::opSlt: begin
                // register ops map straight onto the ALU code.
                aluOp = cpuPkg::aluOpT'(instr.opcode[2:0]);
                useRt = 1'b1;
                regWe = 1'b1;
            end
            cpuPkg::opAddi: begin
                useImm = 1'b1;
                regWe  = 1'b1;
            end
            cpuPkg::opLw: begin
                useImm   = 1'b1;
                regWe    = 1'b1;
                memToReg = 1'b1;
            end
            cpuPkg::opSw: begin
                useImm  = 1'b1;
                isStore = 1'b1;                  // rd is the data source.
            end
            cpuPkg::opBeq: begin
                aluOp    = cpuPkg::aluSub;       // rs - rd, zero on equal.
                isBranch = 1'b1;
            end
            cpuPkg::opJmp:  isJump = 1'b1;
            cpuPkg::opHalt: isHalt = 1'b1;
            default: ;                           // unused codes act as NOP.
        endcase
    end

    // sign-extended immediate.
    assign immExt = cpuPkg::dataT'($signed(instr.tail.imm));
    assign rdB    = useRt ? instr.tail.r.rt : instr.rd;

    // ********************
    // datapath.
    // ********************
    regFile regs (
        .clock  (clock),
        .rstN   (rstN),
        .we     (regWe && !haltedQ),             // nothing retires once halted.
        .rdA    (instr.rs),
        .rdB    (rdB),
        .wrIdx  (instr.rd),
        .wrData (wbData),
        .valA   (valA),
        .valB   (valB)
    );

    assign aluB = useImm ? immExt : valB;

    alu aluUnit (
        .op   (aluOp),
        .a    (valA),
        .b    (aluB),
        .y    (aluY),
        .zero (aluZero)
    );

    assign wbData = memToReg ? dmemRdData : aluY;

    // data memory request, address is rs + imm cut to the memory width.
    assign dmemAddr   = aluY[`CPU_DMEM_AW-1:0];
    assign dmemWrData = valB;
    assign dmemWe     = isStore && !haltedQ && rstN;   // no store while held in reset.

    // ********************
    // next pc.
    // ********************
    assign pcPlus1      = pc + 1'b1;
    assign branchTarget = pcPlus1 + immExt[`CPU_IMEM_AW-1:0];   // relative to pc+1.
    assign jumpTarget   = `CPU_IMEM_AW'(instr.tail.imm);         // absolute.

    always_comb begin
        if (haltedQ || isHalt) begin
            pcNext = pc;                         // park on the HALT.
        end else if (isJump) begin
            pcNext = jumpTarget;
        end else if (isBranch && aluZero) begin
            pcNext = branchTarget;
        end else begin
            pcNext = pcPlus1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            pc      <= '0;
            haltedQ <= 1'b0;
        end else begin
            pc <= pcNext;
            if (isHalt) begin
                haltedQ <= 1'b1;                 // set at the end of HALT's cycle.
            end
        end
    end

    assign imemAddr = pc;
    assign halted   = haltedQ;

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

// combinational ALU for the register ops, address add and branch compare.
module alu (
    input  wire cpuPkg::aluOpT op,
    input  wire cpuPkg::dataT  a,
    input  wire cpuPkg::dataT  b,
    output cpuPkg::dataT       y,
    output logic               zero
);

    always_comb begin
        case (op)
            cpuPkg::aluAdd: y = a + b;                      // wraps at 16 bits.
            cpuPkg::aluSub: y = a - b;
            cpuPkg::aluAnd: y = a & b;
            cpuPkg::aluOr:  y = a | b;
            cpuPkg::aluXor: y = a ^ b;
            cpuPkg::aluSlt: begin
                // two's complement compare, result is 0 or 1.
                y = ($signed(a) < $signed(b)) ? cpuPkg::dataT'(1) : '0;
            end
            default:        y = '0;                         // codes 6 and 7 unused.
        endcase
    end

    // equality test for BEQ, which runs a SUB through here.
    assign zero = (y == '0);

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

// general purpose registers, two read ports and one write port.
module regFile (
    input  wire logic           clock,
    input  wire logic           rstN,
    input  wire logic           we,
    input  wire cpuPkg::regIdxT rdA,
    input  wire cpuPkg::regIdxT rdB,
    input  wire cpuPkg::regIdxT wrIdx,
    input  wire cpuPkg::dataT   wrData,
    output cpuPkg::dataT        valA,
    output cpuPkg::dataT        valB
);

    cpuPkg::dataT regs [`CPU_NUM_REGS];         // r0 slot is never written.

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;                  // clean start per program.
            end
        end else if (we && (wrIdx != '0)) begin
            regs[wrIdx] <= wrData;              // writes to r0 are dropped.
        end
    end

    // combinational reads, r0 always zero.
    assign valA = (rdA == '0) ? '0 : regs[rdA];
    assign valB = (rdB == '0) ? '0 : regs[rdB];

endmodule

`default_nettype wire

/* ram_block.sv */
`timescale 1ns/1ps
`default_nettype none

// word RAM with one synchronous write port and one combinational read port.
module ramBlock #(
    parameter type wordT     = logic [15:0],
    parameter int  depth     = 64,
    parameter int  addrWidth = 6
) (
    input  wire logic                 clock,
    input  wire logic                 we,
    input  wire logic [addrWidth-1:0] wrAddr,
    input  wire logic [addrWidth-1:0] rdAddr,
    input  wire wordT                 wrData,
    output wordT                      rdData
);

    // ********************
    // storage.
    // ********************
    wordT mem [depth];                          // contents survive reset.

    always_ff @(posedge clock) begin
        if (we) begin
            mem[wrAddr] <= wrData;              // lands on the edge.
        end
    end

    // asynchronous read, a load sees any store of an earlier cycle.
    assign rdData = mem[rdAddr];

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

`include "cpu_config.svh"

package cpuPkg;

    // ********************
    // data path words.
    // ********************
    typedef logic [15:0] dataT;                               // one data word.
    typedef logic [$clog2(`CPU_NUM_REGS)-1:0] regIdxT;        // register number.

    // register-format opcodes share their low three bits with aluOpT,
    // the core relies on that to pick the ALU operation.
    typedef enum logic [3:0] {
        opAdd  = 4'h0,
        opSub  = 4'h1,
        opAnd  = 4'h2,
        opOr   = 4'h3,
        opXor  = 4'h4,
        opSlt  = 4'h5,
        opAddi = 4'h6,
        opLw   = 4'h7,
        opSw   = 4'h8,
        opBeq  = 4'h9,
        opJmp  = 4'hA,
        opHalt = 4'hF
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluSlt = 3'd5                                         // signed compare.
    } aluOpT;

    // ********************
    // instruction word.
    // ********************
    typedef struct packed {
        regIdxT     rt;                                       // second source.
        logic [2:0] spare;                                    // unused, write zero.
    } rtFieldT;

    // low six bits hold either rt or the immediate.
    typedef union packed {
        rtFieldT    r;
        logic [5:0] imm;                                      // two's complement.
    } tailT;

    typedef struct packed {
        opcodeT opcode;                                       // bits 15:12.
        regIdxT rd;                                           // bits 11:9.
        regIdxT rs;                                           // bits 8:6.
        tailT   tail;                                         // bits 5:0.
    } instrT;

endpackage

`default_nettype wire

/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// ********************
// memory geometry.
// ********************

// instruction memory, one 16-bit instruction per word.
`define CPU_IMEM_DEPTH 64
`define CPU_IMEM_AW    6      // log2 of the instruction depth.

// data memory, word addressed.
`define CPU_DMEM_DEPTH 64
`define CPU_DMEM_AW    6      // log2 of the data depth.

// ********************
// register file.
// ********************
`define CPU_NUM_REGS   8      // r0 is hardwired to zero.

`endif
